// ==== source/pi_route_pkg.sv ====
/* Pi switch routing package
   Switch dimensions, mux select widths and the direction turn type */
`default_nettype none

package pi_route_pkg;

    // Leaf clients in the whole tree
    localparam int NUM_CLIENTS = 16;
    // Virtual channels per port, VC0 has the highest priority
    localparam int VC_W = 2;
    // One extra bit above the client index
    localparam int ADDR_W = $clog2(NUM_CLIENTS) + 1;

    // Receiver FIFO depth, one slot is never handed out
    localparam int CREDIT_DEPTH = 4;
    localparam int CREDIT_W = $clog2(CREDIT_DEPTH);

    // Side outputs pick from three sources, up outputs from two
    localparam int SIDE_SEL_W = $clog2(VC_W * 3);
    localparam int UP_SEL_W = $clog2(VC_W * 2);

    // Whose turn it is, in round-robin order
    typedef enum logic [1:0] {
        TURN_L  = 2'd0,
        TURN_R  = 2'd1,
        TURN_U0 = 2'd2,
        TURN_U1 = 2'd3
    } turn_e;

endpackage

`default_nettype wire

// ==== source/pi_credit_counter.sv ====
/* Credit counters for one output port
   One counter per VC, zero credits back-pressures that VC */
`timescale 1ns/10ps
`default_nettype none

module pi_credit_counter (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_credit_gnt,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_send,
    output logic      [pi_route_pkg::VC_W-1:0] o_out_bp
);

    logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::CREDIT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int vc = 0; vc < pi_route_pkg::VC_W; vc++) begin
                count[vc] <= pi_route_pkg::CREDIT_W'(pi_route_pkg::CREDIT_DEPTH - 1);
            end
        end else begin
            for (int vc = 0; vc < pi_route_pkg::VC_W; vc++) begin
                // Send and return together cancel out
                case ({i_send[vc], i_credit_gnt[vc]})
                    2'b10:   count[vc] <= count[vc] - 1'b1;
                    2'b01:   count[vc] <= count[vc] + 1'b1;
                    default: count[vc] <= count[vc];
                endcase
            end
        end
    end

    // Empty counter blocks that output VC
    always_comb begin
        for (int vc = 0; vc < pi_route_pkg::VC_W; vc++) begin
            o_out_bp[vc] = (count[vc] == '0);
        end
    end

endmodule

`default_nettype wire

// ==== source/pi_addr_decode.sv ====
/* Destination decode for the Pi switch
   Maps each input VC's address to the output it wants */
`timescale 1ns/10ps
`default_nettype none

module pi_addr_decode #(
    parameter int LEVEL = 1,
    parameter int POS   = 2
) (
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_l_v,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_r_v,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_u0_v,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_u1_v,
    input  wire logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::ADDR_W-1:0] i_l_addr,
    input  wire logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::ADDR_W-1:0] i_r_addr,
    input  wire logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::ADDR_W-1:0] i_u0_addr,
    input  wire logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::ADDR_W-1:0] i_u1_addr,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_l_wants_r,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_l_wants_u0,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_r_wants_l,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_r_wants_u1,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_u0_wants_l,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_u0_wants_r,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_u1_wants_l,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_u1_wants_r
);

    // Address bits above LEVEL identify the subtree
    localparam int HI_W = pi_route_pkg::ADDR_W - LEVEL - 1;
    localparam logic [HI_W-1:0] POS_HI = HI_W'(POS);

    // Destination lies below this switch
    logic [pi_route_pkg::VC_W-1:0] l_local;
    logic [pi_route_pkg::VC_W-1:0] r_local;

    always_comb begin
        for (int vc = 0; vc < pi_route_pkg::VC_W; vc++) begin
            l_local[vc] = (i_l_addr[vc][pi_route_pkg::ADDR_W-1:LEVEL+1] == POS_HI);
            r_local[vc] = (i_r_addr[vc][pi_route_pkg::ADDR_W-1:LEVEL+1] == POS_HI);

            // Left crosses over when bit LEVEL points right, else climbs via u0
            o_l_wants_r[vc]  = i_l_v[vc] & l_local[vc] & i_l_addr[vc][LEVEL];
            o_l_wants_u0[vc] = i_l_v[vc] & ~l_local[vc];

            // Right mirrors left, climbing via u1
            o_r_wants_l[vc]  = i_r_v[vc] & r_local[vc] & ~i_r_addr[vc][LEVEL];
            o_r_wants_u1[vc] = i_r_v[vc] & ~r_local[vc];

            // Downward traffic only splits on bit LEVEL
            o_u0_wants_l[vc] = i_u0_v[vc] & ~i_u0_addr[vc][LEVEL];
            o_u0_wants_r[vc] = i_u0_v[vc] & i_u0_addr[vc][LEVEL];
            o_u1_wants_l[vc] = i_u1_v[vc] & ~i_u1_addr[vc][LEVEL];
            o_u1_wants_r[vc] = i_u1_v[vc] & i_u1_addr[vc][LEVEL];
        end
    end

endmodule

`default_nettype wire

// ==== source/pi_turn_arbiter.sv ====
/* Direction round-robin for the Pi switch
   Turn register and the per-output wins decisions */
`timescale 1ns/10ps
`default_nettype none

module pi_turn_arbiter (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_l_wants_r,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_l_wants_u0,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_r_wants_l,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_r_wants_u1,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_u0_wants_l,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_u0_wants_r,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_u1_wants_l,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_u1_wants_r,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_l_in_bp,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_r_in_bp,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_u0_in_bp,
    input  wire logic [pi_route_pkg::VC_W-1:0] i_u1_in_bp,
    output logic                               o_l_wins_r,
    output logic                               o_u0_wins_r,
    output logic                               o_u1_wins_r,
    output logic                               o_r_wins_l,
    output logic                               o_u0_wins_l,
    output logic                               o_u1_wins_l,
    output logic                               o_l_wins_u0,
    output logic                               o_r_wins_u0,
    output logic                               o_l_wins_u1,
    output logic                               o_r_wins_u1
);

    pi_route_pkg::turn_e turn_q;
    pi_route_pkg::turn_e turn_d;

    // Stalled directions, indexed like turn_e
    logic [3:0] pending;
    logic [1:0] cand;
    logic       found;

    assign pending = {|i_u1_in_bp, |i_u0_in_bp, |i_r_in_bp, |i_l_in_bp};

    // First stalled direction after the current holder, wrapping
    always_comb begin
        turn_d = turn_q;
        found  = 1'b0;
        cand   = turn_q;
        for (int k = 1; k < 4; k++) begin
            cand = turn_q + 2'(k);
            if (!found && pending[cand]) begin
                turn_d = pi_route_pkg::turn_e'(cand);
                found  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            turn_q <= pi_route_pkg::TURN_L;
        end else begin
            turn_q <= turn_d;
        end
    end

    // Holding the turn, or uncontested
    assign o_l_wins_r  = (turn_q == pi_route_pkg::TURN_L) | ~(|{i_u0_wants_r, i_u1_wants_r});
    assign o_u0_wins_r = (turn_q == pi_route_pkg::TURN_U0) | ~(|{i_l_wants_r, i_u1_wants_r});
    assign o_u1_wins_r = (turn_q == pi_route_pkg::TURN_U1) | ~(|{i_l_wants_r, i_u0_wants_r});

    assign o_r_wins_l  = (turn_q == pi_route_pkg::TURN_R) | ~(|{i_u0_wants_l, i_u1_wants_l});
    assign o_u0_wins_l = (turn_q == pi_route_pkg::TURN_U0) | ~(|{i_r_wants_l, i_u1_wants_l});
    assign o_u1_wins_l = (turn_q == pi_route_pkg::TURN_U1) | ~(|{i_r_wants_l, i_u0_wants_l});

    // Only left climbs via u0 and only right via u1
    assign o_l_wins_u0 = 1'b1;
    assign o_r_wins_u0 = (turn_q == pi_route_pkg::TURN_R) | ~(|i_l_wants_u0);
    assign o_l_wins_u1 = (turn_q == pi_route_pkg::TURN_L) | ~(|i_r_wants_u1);
    assign o_r_wins_u1 = 1'b1;

endmodule

`default_nettype wire

// ==== source/pi_output_alloc.sv ====
/* Output allocation for the Pi switch
   Static VC priority grants, valids, input back-pressure and mux selects */
`timescale 1ns/10ps
`default_nettype none

module pi_output_alloc (
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_l_wants_r,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_l_wants_u0,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_r_wants_l,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_r_wants_u1,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_u0_wants_l,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_u0_wants_r,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_u1_wants_l,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_u1_wants_r,
    input  wire logic                                i_l_wins_r,
    input  wire logic                                i_u0_wins_r,
    input  wire logic                                i_u1_wins_r,
    input  wire logic                                i_r_wins_l,
    input  wire logic                                i_u0_wins_l,
    input  wire logic                                i_u1_wins_l,
    input  wire logic                                i_l_wins_u0,
    input  wire logic                                i_r_wins_u0,
    input  wire logic                                i_l_wins_u1,
    input  wire logic                                i_r_wins_u1,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_l_out_bp,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_r_out_bp,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_u0_out_bp,
    input  wire logic [pi_route_pkg::VC_W-1:0]       i_u1_out_bp,
    output logic      [pi_route_pkg::VC_W-1:0]       o_l_v,
    output logic      [pi_route_pkg::VC_W-1:0]       o_r_v,
    output logic      [pi_route_pkg::VC_W-1:0]       o_u0_v,
    output logic      [pi_route_pkg::VC_W-1:0]       o_u1_v,
    output logic      [pi_route_pkg::VC_W-1:0]       o_l_in_bp,
    output logic      [pi_route_pkg::VC_W-1:0]       o_r_in_bp,
    output logic      [pi_route_pkg::VC_W-1:0]       o_u0_in_bp,
    output logic      [pi_route_pkg::VC_W-1:0]       o_u1_in_bp,
    output logic      [pi_route_pkg::SIDE_SEL_W-1:0] o_l_sel,
    output logic      [pi_route_pkg::SIDE_SEL_W-1:0] o_r_sel,
    output logic      [pi_route_pkg::UP_SEL_W-1:0]   o_u0_sel,
    output logic      [pi_route_pkg::UP_SEL_W-1:0]   o_u1_sel
);

    // Lowest wanting VC with credit when the source won the output
    function automatic logic [pi_route_pkg::VC_W-1:0] vc_grant(
        input logic [pi_route_pkg::VC_W-1:0] want,
        input logic [pi_route_pkg::VC_W-1:0] out_bp,
        input logic                          wins
    );
        logic [pi_route_pkg::VC_W-1:0] gnt;
        logic                          taken;
        taken = 1'b0;
        for (int vc = 0; vc < pi_route_pkg::VC_W; vc++) begin
            gnt[vc] = want[vc] & ~out_bp[vc] & wins & ~taken;
            taken   = taken | gnt[vc];
        end
        return gnt;
    endfunction

    // Binary index of a one-hot word or zero when idle
    function automatic logic [pi_route_pkg::SIDE_SEL_W-1:0] onehot_index(
        input logic [pi_route_pkg::VC_W*3-1:0] oh
    );
        logic [pi_route_pkg::SIDE_SEL_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < pi_route_pkg::VC_W * 3; i++) begin
            if (oh[i]) begin
                idx = i[pi_route_pkg::SIDE_SEL_W-1:0];
            end
        end
        return idx;
    endfunction

    logic [pi_route_pkg::VC_W-1:0]       l_gets_r, u0_gets_r, u1_gets_r;
    logic [pi_route_pkg::VC_W-1:0]       r_gets_l, u0_gets_l, u1_gets_l;
    logic [pi_route_pkg::VC_W-1:0]       l_gets_u0, r_gets_u1;
    logic [pi_route_pkg::SIDE_SEL_W-1:0] u0_idx, u1_idx;

    assign l_gets_r  = vc_grant(i_l_wants_r, i_r_out_bp, i_l_wins_r);
    assign u0_gets_r = vc_grant(i_u0_wants_r, i_r_out_bp, i_u0_wins_r);
    assign u1_gets_r = vc_grant(i_u1_wants_r, i_r_out_bp, i_u1_wins_r);

    assign r_gets_l  = vc_grant(i_r_wants_l, i_l_out_bp, i_r_wins_l);
    assign u0_gets_l = vc_grant(i_u0_wants_l, i_l_out_bp, i_u0_wins_l);
    assign u1_gets_l = vc_grant(i_u1_wants_l, i_l_out_bp, i_u1_wins_l);

    // Left climbs only via u0 and right only via u1
    assign l_gets_u0 = vc_grant(i_l_wants_u0, i_u0_out_bp, i_l_wins_u0);
    assign r_gets_u1 = vc_grant(i_r_wants_u1, i_u1_out_bp, i_r_wins_u1);

    // Per-output valids
    assign o_l_v  = r_gets_l | u0_gets_l | u1_gets_l;
    assign o_r_v  = l_gets_r | u0_gets_r | u1_gets_r;
    assign o_u0_v = l_gets_u0;
    assign o_u1_v = r_gets_u1;

    // Wanted but not granted holds the head packet
    assign o_l_in_bp  = (i_l_wants_r & ~l_gets_r) | (i_l_wants_u0 & ~l_gets_u0);
    assign o_r_in_bp  = (i_r_wants_l & ~r_gets_l) | (i_r_wants_u1 & ~r_gets_u1);
    assign o_u0_in_bp = (i_u0_wants_l & ~u0_gets_l) | (i_u0_wants_r & ~u0_gets_r);
    assign o_u1_in_bp = (i_u1_wants_l & ~u1_gets_l) | (i_u1_wants_r & ~u1_gets_r);

    // Side muxes with u1 in the low slots
    assign o_l_sel = onehot_index({r_gets_l, u0_gets_l, u1_gets_l});
    assign o_r_sel = onehot_index({l_gets_r, u0_gets_r, u1_gets_r});

    // Up muxes with r in the low slots and l above
    assign u0_idx   = onehot_index({{pi_route_pkg::VC_W{1'b0}}, l_gets_u0,
                                    {pi_route_pkg::VC_W{1'b0}}});
    assign u1_idx   = onehot_index({{(2 * pi_route_pkg::VC_W){1'b0}}, r_gets_u1});
    assign o_u0_sel = u0_idx[pi_route_pkg::UP_SEL_W-1:0];
    assign o_u1_sel = u1_idx[pi_route_pkg::UP_SEL_W-1:0];

endmodule

`default_nettype wire

// ==== source/pi_route_top.sv ====
/* Pi switch routing decision, top level
   Credit tracking, address decode, direction turn and output allocation */
`timescale 1ns/10ps
`default_nettype none

module pi_route_top #(
    parameter int LEVEL = 1,
    parameter int POS   = 2
) (
    input  wire logic                                                   clk,
    input  wire logic                                                   rst,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_l_v,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_r_v,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_u0_v,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_u1_v,
    input  wire logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::ADDR_W-1:0] i_l_addr,
    input  wire logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::ADDR_W-1:0] i_r_addr,
    input  wire logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::ADDR_W-1:0] i_u0_addr,
    input  wire logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::ADDR_W-1:0] i_u1_addr,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_l_credit_gnt,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_r_credit_gnt,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_u0_credit_gnt,
    input  wire logic [pi_route_pkg::VC_W-1:0]                          i_u1_credit_gnt,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_l_in_bp,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_r_in_bp,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_u0_in_bp,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_u1_in_bp,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_l_v,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_r_v,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_u0_v,
    output logic      [pi_route_pkg::VC_W-1:0]                          o_u1_v,
    output logic      [pi_route_pkg::SIDE_SEL_W-1:0]                    o_l_sel,
    output logic      [pi_route_pkg::SIDE_SEL_W-1:0]                    o_r_sel,
    output logic      [pi_route_pkg::UP_SEL_W-1:0]                      o_u0_sel,
    output logic      [pi_route_pkg::UP_SEL_W-1:0]                      o_u1_sel
);

    // Output VCs out of credit
    logic [pi_route_pkg::VC_W-1:0] l_out_bp, r_out_bp, u0_out_bp, u1_out_bp;

    // Decoded requests
    logic [pi_route_pkg::VC_W-1:0] l_wants_r, l_wants_u0, r_wants_l, r_wants_u1;
    logic [pi_route_pkg::VC_W-1:0] u0_wants_l, u0_wants_r, u1_wants_l, u1_wants_r;

    // Direction arbitration results
    logic l_wins_r, u0_wins_r, u1_wins_r, r_wins_l, u0_wins_l, u1_wins_l;
    logic l_wins_u0, r_wins_u0, l_wins_u1, r_wins_u1;

    // Each counter spends a credit on its own output valid
    pi_credit_counter u_l_credit (
        .clk(clk), .rst(rst), .i_credit_gnt(i_l_credit_gnt), .i_send(o_l_v), .o_out_bp(l_out_bp)
    );
    pi_credit_counter u_r_credit (
        .clk(clk), .rst(rst), .i_credit_gnt(i_r_credit_gnt), .i_send(o_r_v), .o_out_bp(r_out_bp)
    );
    pi_credit_counter u_u0_credit (
        .clk(clk), .rst(rst), .i_credit_gnt(i_u0_credit_gnt), .i_send(o_u0_v),
        .o_out_bp(u0_out_bp)
    );
    pi_credit_counter u_u1_credit (
        .clk(clk), .rst(rst), .i_credit_gnt(i_u1_credit_gnt), .i_send(o_u1_v),
        .o_out_bp(u1_out_bp)
    );

    pi_addr_decode #(.LEVEL(LEVEL), .POS(POS)) u_decode (
        .i_l_v(i_l_v), .i_r_v(i_r_v), .i_u0_v(i_u0_v), .i_u1_v(i_u1_v),
        .i_l_addr(i_l_addr), .i_r_addr(i_r_addr), .i_u0_addr(i_u0_addr), .i_u1_addr(i_u1_addr),
        .o_l_wants_r(l_wants_r), .o_l_wants_u0(l_wants_u0),
        .o_r_wants_l(r_wants_l), .o_r_wants_u1(r_wants_u1),
        .o_u0_wants_l(u0_wants_l), .o_u0_wants_r(u0_wants_r),
        .o_u1_wants_l(u1_wants_l), .o_u1_wants_r(u1_wants_r)
    );

    // Input back-pressure feeds back only through the registered turn
    pi_turn_arbiter u_turn (
        .clk(clk), .rst(rst),
        .i_l_wants_r(l_wants_r), .i_l_wants_u0(l_wants_u0),
        .i_r_wants_l(r_wants_l), .i_r_wants_u1(r_wants_u1),
        .i_u0_wants_l(u0_wants_l), .i_u0_wants_r(u0_wants_r),
        .i_u1_wants_l(u1_wants_l), .i_u1_wants_r(u1_wants_r),
        .i_l_in_bp(o_l_in_bp), .i_r_in_bp(o_r_in_bp),
        .i_u0_in_bp(o_u0_in_bp), .i_u1_in_bp(o_u1_in_bp),
        .o_l_wins_r(l_wins_r), .o_u0_wins_r(u0_wins_r), .o_u1_wins_r(u1_wins_r),
        .o_r_wins_l(r_wins_l), .o_u0_wins_l(u0_wins_l), .o_u1_wins_l(u1_wins_l),
        .o_l_wins_u0(l_wins_u0), .o_r_wins_u0(r_wins_u0),
        .o_l_wins_u1(l_wins_u1), .o_r_wins_u1(r_wins_u1)
    );

    pi_output_alloc u_alloc (
        .i_l_wants_r(l_wants_r), .i_l_wants_u0(l_wants_u0),
        .i_r_wants_l(r_wants_l), .i_r_wants_u1(r_wants_u1),
        .i_u0_wants_l(u0_wants_l), .i_u0_wants_r(u0_wants_r),
        .i_u1_wants_l(u1_wants_l), .i_u1_wants_r(u1_wants_r),
        .i_l_wins_r(l_wins_r), .i_u0_wins_r(u0_wins_r), .i_u1_wins_r(u1_wins_r),
        .i_r_wins_l(r_wins_l), .i_u0_wins_l(u0_wins_l), .i_u1_wins_l(u1_wins_l),
        .i_l_wins_u0(l_wins_u0), .i_r_wins_u0(r_wins_u0),
        .i_l_wins_u1(l_wins_u1), .i_r_wins_u1(r_wins_u1),
        .i_l_out_bp(l_out_bp), .i_r_out_bp(r_out_bp),
        .i_u0_out_bp(u0_out_bp), .i_u1_out_bp(u1_out_bp),
        .o_l_v(o_l_v), .o_r_v(o_r_v), .o_u0_v(o_u0_v), .o_u1_v(o_u1_v),
        .o_l_in_bp(o_l_in_bp), .o_r_in_bp(o_r_in_bp),
        .o_u0_in_bp(o_u0_in_bp), .o_u1_in_bp(o_u1_in_bp),
        .o_l_sel(o_l_sel), .o_r_sel(o_r_sel), .o_u0_sel(o_u0_sel), .o_u1_sel(o_u1_sel)
    );

endmodule

`default_nettype wire

// ==== verification/pi_route_tb.sv ====
/* Testbench for the Pi switch routing block
   Replays per-cycle cases from a file and checks every output */
`timescale 1ns/10ps
`default_nettype none

module pi_route_tb;

    // Columns per case line, expected values start at column 16
    localparam int NUM_COLS  = 28;
    localparam int EXP_COL   = 16;
    localparam int MAX_LINES = 64;

    logic clk;
    logic rst;

    // DUT stimulus
    logic [pi_route_pkg::VC_W-1:0] l_v, r_v, u0_v, u1_v;
    logic [pi_route_pkg::VC_W-1:0][pi_route_pkg::ADDR_W-1:0] l_addr, r_addr, u0_addr, u1_addr;
    logic [pi_route_pkg::VC_W-1:0] l_credit_gnt, r_credit_gnt, u0_credit_gnt, u1_credit_gnt;

    // DUT responses
    logic [pi_route_pkg::VC_W-1:0]       l_out_v, r_out_v, u0_out_v, u1_out_v;
    logic [pi_route_pkg::VC_W-1:0]       l_in_bp, r_in_bp, u0_in_bp, u1_in_bp;
    logic [pi_route_pkg::SIDE_SEL_W-1:0] l_sel, r_sel;
    logic [pi_route_pkg::UP_SEL_W-1:0]   u0_sel, u1_sel;

    // One byte per column, whole file in one flat array
    logic [7:0] cases_mem [0:MAX_LINES*NUM_COLS-1];

    int checks;
    int errors;

    pi_route_top #(.LEVEL(1), .POS(2)) dut (
        .clk(clk), .rst(rst),
        .i_l_v(l_v), .i_r_v(r_v), .i_u0_v(u0_v), .i_u1_v(u1_v),
        .i_l_addr(l_addr), .i_r_addr(r_addr), .i_u0_addr(u0_addr), .i_u1_addr(u1_addr),
        .i_l_credit_gnt(l_credit_gnt), .i_r_credit_gnt(r_credit_gnt),
        .i_u0_credit_gnt(u0_credit_gnt), .i_u1_credit_gnt(u1_credit_gnt),
        .o_l_in_bp(l_in_bp), .o_r_in_bp(r_in_bp), .o_u0_in_bp(u0_in_bp), .o_u1_in_bp(u1_in_bp),
        .o_l_v(l_out_v), .o_r_v(r_out_v), .o_u0_v(u0_out_v), .o_u1_v(u1_out_v),
        .o_l_sel(l_sel), .o_r_sel(r_sel), .o_u0_sel(u0_sel), .o_u1_sel(u1_sel)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic clear_inputs();
        l_v = '0;
        r_v = '0;
        u0_v = '0;
        u1_v = '0;
        l_addr = '0;
        r_addr = '0;
        u0_addr = '0;
        u1_addr = '0;
        l_credit_gnt = '0;
        r_credit_gnt = '0;
        u0_credit_gnt = '0;
        u1_credit_gnt = '0;
    endtask

    // Columns 0 to 15, valids then addresses then credit returns
    task automatic drive_case(input int base);
        l_v  = cases_mem[base][pi_route_pkg::VC_W-1:0];
        r_v  = cases_mem[base + 1][pi_route_pkg::VC_W-1:0];
        u0_v = cases_mem[base + 2][pi_route_pkg::VC_W-1:0];
        u1_v = cases_mem[base + 3][pi_route_pkg::VC_W-1:0];
        l_addr[0]  = cases_mem[base + 4][pi_route_pkg::ADDR_W-1:0];
        l_addr[1]  = cases_mem[base + 5][pi_route_pkg::ADDR_W-1:0];
        r_addr[0]  = cases_mem[base + 6][pi_route_pkg::ADDR_W-1:0];
        r_addr[1]  = cases_mem[base + 7][pi_route_pkg::ADDR_W-1:0];
        u0_addr[0] = cases_mem[base + 8][pi_route_pkg::ADDR_W-1:0];
        u0_addr[1] = cases_mem[base + 9][pi_route_pkg::ADDR_W-1:0];
        u1_addr[0] = cases_mem[base + 10][pi_route_pkg::ADDR_W-1:0];
        u1_addr[1] = cases_mem[base + 11][pi_route_pkg::ADDR_W-1:0];
        l_credit_gnt  = cases_mem[base + 12][pi_route_pkg::VC_W-1:0];
        r_credit_gnt  = cases_mem[base + 13][pi_route_pkg::VC_W-1:0];
        u0_credit_gnt = cases_mem[base + 14][pi_route_pkg::VC_W-1:0];
        u1_credit_gnt = cases_mem[base + 15][pi_route_pkg::VC_W-1:0];
    endtask

    task automatic check_field(input string name, input logic [7:0] got,
                               input logic [7:0] exp, input int line);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s case %0d: expected 0x%02h, got 0x%02h", name, line, exp, got);
        end
    endtask

    // Valids, input back-pressure, then selects
    task automatic compare_outputs(input int base, input int line);
        int e;
        e = base + EXP_COL;
        check_field("o_l_v", 8'(l_out_v), cases_mem[e], line);
        check_field("o_r_v", 8'(r_out_v), cases_mem[e + 1], line);
        check_field("o_u0_v", 8'(u0_out_v), cases_mem[e + 2], line);
        check_field("o_u1_v", 8'(u1_out_v), cases_mem[e + 3], line);
        check_field("o_l_in_bp", 8'(l_in_bp), cases_mem[e + 4], line);
        check_field("o_r_in_bp", 8'(r_in_bp), cases_mem[e + 5], line);
        check_field("o_u0_in_bp", 8'(u0_in_bp), cases_mem[e + 6], line);
        check_field("o_u1_in_bp", 8'(u1_in_bp), cases_mem[e + 7], line);
        check_field("o_l_sel", 8'(l_sel), cases_mem[e + 8], line);
        check_field("o_r_sel", 8'(r_sel), cases_mem[e + 9], line);
        check_field("o_u0_sel", 8'(u0_sel), cases_mem[e + 10], line);
        check_field("o_u1_sel", 8'(u1_sel), cases_mem[e + 11], line);
    endtask

    initial begin
        int  line;
        int  base;
        bit  done;
        checks = 0;
        errors = 0;
        clk = 1'b0;
        rst = 1'b1;
        clear_inputs();
        // Unloaded slots read back with bit 7 set, which no column uses
        for (int i = 0; i < MAX_LINES * NUM_COLS; i++) begin
            cases_mem[i] = 8'h80 | 8'(i % 127);
        end
        $readmemh("verification/pi_route_cases.txt", cases_mem);

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // One case per cycle, driven on the falling edge
        line = 0;
        done = 1'b0;
        while (!done) begin
            base = line * NUM_COLS;
            if (line >= MAX_LINES) begin
                $display("Timeout: no end of the cases found within %0d lines", MAX_LINES);
                errors++;
                done = 1'b1;
            end else if (cases_mem[base][7]) begin
                done = 1'b1;
            end else begin
                drive_case(base);
                // Outputs are combinational, settled well before the rising edge
                #1;
                compare_outputs(base, line);
                @(negedge clk);
                line++;
            end
        end
        clear_inputs();

        if (line == 0) begin
            $display("No cases were loaded from the cases file");
            errors++;
        end

        $display("Cases run: %0d, checks: %0d, errors: %0d", line, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/pi_route_cases.txt ====
// lv rv u0v u1v | l/r/u0/u1 addr VC0 VC1 | l r u0 u1 credit gnt | expected:
// l r u0 u1 valid | l r u0 u1 in_bp | l r u0 u1 sel   (LEVEL 1, POS 2, all hex)
// Idle after reset
0 0 0 0  00 00 00 00 00 00 00 00  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0
// l and u0 both want r, turn starts at l, then moves to u0
1 0 1 0  0A 00 00 00 02 00 00 00  0 0 0 0  0 1 0 0  0 0 1 0  0 4 0 0
1 0 1 0  0A 00 00 00 02 00 00 00  0 0 0 0  0 1 0 0  1 0 0 0  0 2 0 0
// Third send on r VC0 empties it, then blocked until a credit returns
1 0 0 0  0A 00 00 00 00 00 00 00  0 0 0 0  0 1 0 0  0 0 0 0  0 4 0 0
1 0 0 0  0A 00 00 00 00 00 00 00  0 1 0 0  0 0 0 0  1 0 0 0  0 0 0 0
1 0 0 0  0A 00 00 00 00 00 00 00  0 0 0 0  0 1 0 0  0 0 0 0  0 4 0 0
0 0 0 0  00 00 00 00 00 00 00 00  0 1 0 0  0 0 0 0  0 0 0 0  0 0 0 0
// Both l VCs want r, VC0 first
3 0 0 0  0B 0A 00 00 00 00 00 00  0 0 0 0  0 1 0 0  2 0 0 0  0 4 0 0
2 0 0 0  00 0A 00 00 00 00 00 00  0 0 0 0  0 2 0 0  0 0 0 0  0 5 0 0
// Decode, one source at a time
1 0 0 0  00 00 00 00 00 00 00 00  0 0 0 0  0 0 1 0  0 0 0 0  0 0 2 0
0 1 0 0  00 00 10 00 00 00 00 00  0 0 0 0  0 0 0 1  0 0 0 0  0 0 0 0
0 2 0 0  00 00 00 09 00 00 00 00  0 0 0 0  2 0 0 0  0 0 0 0  5 0 0 0
0 0 1 0  00 00 00 00 04 00 00 00  0 0 0 0  1 0 0 0  0 0 0 0  2 0 0 0
0 0 0 2  00 00 00 00 00 00 00 06  0 0 0 0  0 2 0 0  0 0 0 0  0 1 0 0
0 0 0 1  00 00 00 00 00 00 01 00  0 0 0 0  1 0 0 0  0 0 0 0  0 0 0 0
// l and r climb together
1 1 0 0  00 00 1F 00 00 00 00 00  0 0 0 0  0 0 1 1  0 0 0 0  0 0 2 0
2 0 0 0  00 13 00 00 00 00 00 00  0 0 0 0  0 0 2 0  0 0 0 0  0 0 3 0
0 1 0 0  00 00 08 00 00 00 00 00  0 0 0 0  1 0 0 0  0 0 0 0  4 0 0 0
0 0 0 0  00 00 00 00 00 00 00 00  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0

// ==== filelist.f ====
source/pi_route_pkg.sv
source/pi_credit_counter.sv
source/pi_addr_decode.sv
source/pi_turn_arbiter.sv
source/pi_output_alloc.sv
source/pi_route_top.sv
verification/pi_route_tb.sv

// ==== Makefile ====
# Verilator build and run for the Pi switch routing block
TOP := pi_route_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
